// File: list.f
+incdir+source
source/rv32i_types_pkg.sv
source/pipe_ctrl_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/exe_stage.sv
source/mem_stage.sv
source/mem_arbiter.sv
source/rv32i_pipe_top.sv
tb/tb_rv32i_pipe.sv

// File: Bender.yml
package:
  name: rv32i_pipe

sources:
  - include_dirs:
      - source
    files:
      - source/rv32i_types_pkg.sv
      - source/pipe_ctrl_pkg.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/exe_stage.sv
      - source/mem_stage.sv
      - source/mem_arbiter.sv
      - source/rv32i_pipe_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_rv32i_pipe.sv

// File: tb/tb_rv32i_pipe.sv
`timescale 1ns/1ps
`include "core_params.svh"

module tb_rv32i_pipe;

    localparam int CLK_PERIOD = 40;

    logic clk;
    logic rst_i;
    logic mem_read_o;
    logic mem_write_o;
    rv32i_types_pkg::word_t mem_addr_o;
    rv32i_types_pkg::word_t mem_wdata_o;
    rv32i_types_pkg::word_t mem_rdata_i;
    logic mem_resp_i;
    logic commit_valid_o;
    rv32i_types_pkg::word_t commit_pc_o;
    rv32i_types_pkg::reg_idx_t commit_rd_o;
    rv32i_types_pkg::word_t commit_data_o;

    rv32i_types_pkg::word_t mem [256];
    rv32i_types_pkg::word_t ref_mem [256];
    rv32i_types_pkg::word_t exp_pc [$];
    rv32i_types_pkg::reg_idx_t exp_rd [$];
    rv32i_types_pkg::word_t exp_data [$];
    rv32i_types_pkg::word_t exp_st_addr [$];
    rv32i_types_pkg::word_t exp_st_data [$];
    int prog_len = 0;
    int errors = 0;
    int commit_idx = 0;
    int store_idx = 0;
    logic req_open;  // memory model state
    logic first_read_seen;
    int wait_cnt;
    rv32i_types_pkg::word_t open_addr;

    rv32i_pipe_top dut (
        .clk, .rst_i, .mem_read_o, .mem_write_o, .mem_addr_o, .mem_wdata_o,
        .mem_rdata_i, .mem_resp_i, .commit_valid_o, .commit_pc_o, .commit_rd_o,
        .commit_data_o
    );

    function automatic rv32i_types_pkg::word_t r_type(logic sub, rv32i_types_pkg::reg_idx_t rd,
            rv32i_types_pkg::reg_idx_t rs1, rv32i_types_pkg::reg_idx_t rs2);
        rv32i_types_pkg::instr_u u;
        u.r_i.funct7 = sub ? 7'b0100000 : 7'b0000000;
        u.r_i.rs2 = rs2;
        u.r_i.rs1 = rs1;
        u.r_i.funct3 = 3'b000;
        u.r_i.rd = rd;
        u.r_i.opcode = rv32i_types_pkg::opc_op;
        return u;
    endfunction

    // addi or lw, imm split over the funct7 and rs2 fields
    function automatic rv32i_types_pkg::word_t i_type(rv32i_types_pkg::opcode_t opc,
            rv32i_types_pkg::reg_idx_t rd, rv32i_types_pkg::reg_idx_t rs1, logic [11:0] imm);
        rv32i_types_pkg::instr_u u;
        u.r_i.funct7 = imm[11:5];
        u.r_i.rs2 = imm[4:0];
        u.r_i.rs1 = rs1;
        u.r_i.funct3 = (opc == rv32i_types_pkg::opc_load) ? 3'b010 : 3'b000;
        u.r_i.rd = rd;
        u.r_i.opcode = opc;
        return u;
    endfunction

    function automatic rv32i_types_pkg::word_t s_type(rv32i_types_pkg::reg_idx_t rs2,
            rv32i_types_pkg::reg_idx_t rs1, logic [11:0] imm);
        rv32i_types_pkg::instr_u u;
        u.s.imm_11_5 = imm[11:5];
        u.s.rs2 = rs2;
        u.s.rs1 = rs1;
        u.s.funct3 = 3'b010;
        u.s.imm_4_0 = imm[4:0];
        u.s.opcode = rv32i_types_pkg::opc_store;
        return u;
    endfunction

    function automatic rv32i_types_pkg::word_t u_type(rv32i_types_pkg::reg_idx_t rd,
            logic [19:0] imm20);
        return {imm20, rd, rv32i_types_pkg::opc_lui};
    endfunction

    task automatic place_instr(rv32i_types_pkg::word_t w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            // top words preloaded with their own byte address
            mem[a] = (a >= 224) ? (32'hc0de_0000 | (a << 2)) : '0;
        end
        place_instr(i_type(rv32i_types_pkg::opc_op_imm, 5'd1, 5'd0, 12'd5));
        place_instr(i_type(rv32i_types_pkg::opc_op_imm, 5'd2, 5'd0, 12'hffd));  // -3
        place_instr(r_type(1'b0, 5'd3, 5'd1, 5'd2));  // back to back on x2
        place_instr(r_type(1'b1, 5'd4, 5'd3, 5'd1));
        place_instr(r_type(1'b0, 5'd5, 5'd1, 5'd3));  // x3 one apart
        place_instr(u_type(5'd6, 20'h12345));
        place_instr(i_type(rv32i_types_pkg::opc_op_imm, 5'd6, 5'd6, 12'h678));
        place_instr(r_type(1'b0, 5'd0, 5'd1, 5'd1));  // x0 stays zero
        place_instr(r_type(1'b0, 5'd7, 5'd0, 5'd1));
        place_instr(i_type(rv32i_types_pkg::opc_op_imm, 5'd10, 5'd0, 12'h300));
        place_instr(s_type(5'd6, 5'd10, 12'h000));
        place_instr(i_type(rv32i_types_pkg::opc_load, 5'd8, 5'd10, 12'h000));
        place_instr(r_type(1'b0, 5'd9, 5'd8, 5'd1));  // load use
        place_instr(s_type(5'd9, 5'd10, 12'h004));
        place_instr(i_type(rv32i_types_pkg::opc_load, 5'd11, 5'd10, 12'h004));
        place_instr(r_type(1'b1, 5'd12, 5'd11, 5'd8));
        place_instr(i_type(rv32i_types_pkg::opc_load, 5'd13, 5'd10, 12'h080));
        place_instr(i_type(rv32i_types_pkg::opc_op_imm, 5'd14, 5'd13, 12'd1));
        place_instr(r_type(1'b1, 5'd15, 5'd0, 5'd14));
        place_instr(s_type(5'd15, 5'd10, 12'hffc));
        place_instr(i_type(rv32i_types_pkg::opc_load, 5'd16, 5'd10, 12'hffc));
        place_instr(r_type(1'b0, 5'd17, 5'd16, 5'd16));
    endtask

    // architectural model, one instruction per step
    function automatic void run_reference();
        rv32i_types_pkg::word_t regs [32];
        rv32i_types_pkg::word_t w;
        rv32i_types_pkg::word_t a;
        rv32i_types_pkg::word_t b;
        rv32i_types_pkg::word_t res;
        rv32i_types_pkg::word_t ea;
        rv32i_types_pkg::reg_idx_t rd;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        for (int i = 0; i < 256; i++) ref_mem[i] = mem[i];
        for (int p = 0; p < prog_len; p++) begin
            w = ref_mem[p];
            rd = w[11:7];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            res = '0;
            case (rv32i_types_pkg::opcode_t'(w[6:0]))
                rv32i_types_pkg::opc_op:     res = w[30] ? a - b : a + b;
                rv32i_types_pkg::opc_op_imm: res = a + {{20{w[31]}}, w[31:20]};
                rv32i_types_pkg::opc_lui:    res = {w[31:12], 12'h000};
                rv32i_types_pkg::opc_load: begin
                    ea = a + {{20{w[31]}}, w[31:20]};
                    res = ref_mem[ea[9:2]];
                end
                default: begin  // store, the only other kind in the program
                    ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    ref_mem[ea[9:2]] = b;
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                    rd = '0;
                end
            endcase
            if (rd != '0) regs[rd] = res;
            else res = '0;
            exp_pc.push_back(`RESET_PC + p * 4);
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
    endfunction

    task automatic check_commit(string name, rv32i_types_pkg::word_t exp_pc_v,
            rv32i_types_pkg::reg_idx_t exp_rd_v, rv32i_types_pkg::word_t exp_data_v,
            rv32i_types_pkg::word_t act_pc, rv32i_types_pkg::reg_idx_t act_rd,
            rv32i_types_pkg::word_t act_data);
        if (act_pc !== exp_pc_v || act_rd !== exp_rd_v || act_data !== exp_data_v) begin
            errors++;
            $display("FAIL %s: expected pc %h rd %0d data %h, actual pc %h rd %0d data %h",
                     name, exp_pc_v, exp_rd_v, exp_data_v, act_pc, act_rd, act_data);
        end
    endtask

    task automatic check_store(string name, rv32i_types_pkg::word_t exp_addr,
            rv32i_types_pkg::word_t exp_wdata, rv32i_types_pkg::word_t act_addr,
            rv32i_types_pkg::word_t act_wdata);
        if (act_addr !== exp_addr || act_wdata !== exp_wdata) begin
            errors++;
            $display("FAIL %s: expected addr %h data %h, actual addr %h data %h",
                     name, exp_addr, exp_wdata, act_addr, act_wdata);
        end
    endtask

    task automatic check_fetch_addr(string name, rv32i_types_pkg::word_t exp_addr,
            rv32i_types_pkg::word_t act_addr);
        if (act_addr !== exp_addr) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp_addr, act_addr);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory with 1 to 4 cycles of latency, writes land on the response
    always @(negedge clk) begin
        if (rst_i) begin
            mem_resp_i <= 1'b0;
            req_open = 1'b0;
            first_read_seen = 1'b0;
        end else begin
            mem_resp_i <= 1'b0;
            if (req_open) begin
                if (!(mem_read_o || mem_write_o) || mem_addr_o !== open_addr) begin
                    errors++;
                    $display("memory request dropped or moved before its response");
                end
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    req_open = 1'b0;
                    mem_resp_i <= 1'b1;
                    if (mem_write_o) begin
                        if (store_idx >= exp_st_addr.size()) begin
                            errors++;
                            $display("unexpected store to %h", mem_addr_o);
                        end else begin
                            check_store($sformatf("store %0d", store_idx),
                                        exp_st_addr[store_idx], exp_st_data[store_idx],
                                        mem_addr_o, mem_wdata_o);
                        end
                        store_idx++;
                        mem[mem_addr_o[9:2]] = mem_wdata_o;
                    end else begin
                        mem_rdata_i <= mem[mem_addr_o[9:2]];
                    end
                end
            end else if (mem_read_o || mem_write_o) begin
                req_open = 1'b1;
                open_addr = mem_addr_o;
                wait_cnt = 1 + ($urandom % 4);
                if (!first_read_seen && mem_read_o) begin
                    check_fetch_addr("first fetch after reset", `RESET_PC, mem_addr_o);
                    first_read_seen = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_i && commit_valid_o === 1'b1) begin
            if (commit_idx >= exp_pc.size()) begin
                errors++;
                $display("extra commit at pc %h beyond the program", commit_pc_o);
            end else begin
                check_commit($sformatf("commit %0d", commit_idx), exp_pc[commit_idx],
                             exp_rd[commit_idx], exp_data[commit_idx],
                             commit_pc_o, commit_rd_o, commit_data_o);
            end
            commit_idx++;
        end
    end

    initial begin
        wait (prog_len != 0);
        repeat (prog_len * 4 * 5 * 3) @(posedge clk);
        $display("timeout with %0d of %0d commits seen", commit_idx, exp_pc.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(78294));
        rst_i = 1'b1;
        mem_resp_i = 1'b0;
        mem_rdata_i = '0;
        load_program();
        run_reference();
        repeat (10) begin
            @(negedge clk);
            if (mem_write_o !== 1'b0 || commit_valid_o !== 1'b0) begin
                errors++;
                $display("memory write or commit active during reset");
            end
        end
        rst_i <= 1'b0;
        wait (commit_idx >= exp_pc.size());
        repeat (30) @(negedge clk);  // zero words behind the program must stay silent
        if (store_idx != exp_st_addr.size()) begin
            errors++;
            $display("only %0d of %0d stores reached memory", store_idx, exp_st_addr.size());
        end
        $display("errors %0d, commits %0d of %0d, stores %0d of %0d", errors, commit_idx,
                 exp_pc.size(), store_idx, exp_st_addr.size());
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: source/rv32i_pipe_top.sv
`timescale 1ns/1ps
`include "core_params.svh"

module rv32i_pipe_top (
    input  logic                       clk,
    input  logic                       rst_i,
    output logic                       mem_read_o,
    output logic                       mem_write_o,
    output logic [`XLEN-1:0]           mem_addr_o,
    output logic [`XLEN-1:0]           mem_wdata_o,
    input  logic [`XLEN-1:0]           mem_rdata_i,
    input  logic                       mem_resp_i,
    output logic                       commit_valid_o,
    output rv32i_types_pkg::word_t     commit_pc_o,
    output rv32i_types_pkg::reg_idx_t  commit_rd_o,
    output rv32i_types_pkg::word_t     commit_data_o
);

    logic fetch_req, fetch_resp, if_valid, de_hold;
    rv32i_types_pkg::word_t fetch_addr, fetch_rdata, if_pc, if_instr;

    logic wb_en, de_valid, de_mem_read, de_mem_write, de_reg_write;
    rv32i_types_pkg::reg_idx_t wb_rd, de_rs1, de_rs2, de_rd;
    rv32i_types_pkg::word_t wb_data, de_pc, de_rs1_data, de_rs2_data, de_imm;
    pipe_ctrl_pkg::alu_op_t de_alu_op;
    pipe_ctrl_pkg::wb_src_t de_wb_src, ex_wb_src;

    logic mem_busy, fwd_pending, exe_busy, ex_valid, ex_mem_read, ex_mem_write, ex_reg_write;
    rv32i_types_pkg::word_t ex_pc, ex_result, ex_store_data;
    rv32i_types_pkg::reg_idx_t ex_rd;

    logic data_read, data_write, data_resp;
    rv32i_types_pkg::word_t data_addr, data_wdata, data_rdata;

    fetch_stage u_fetch (
        .clk, .rst_i, .if_hold_i(de_hold),
        .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
        .fetch_resp_i(fetch_resp), .fetch_rdata_i(fetch_rdata),
        .if_valid_o(if_valid), .if_pc_o(if_pc), .if_instr_o(if_instr)
    );

    decode_stage u_decode (
        .clk, .rst_i, .if_valid_i(if_valid), .if_pc_i(if_pc), .if_instr_i(if_instr),
        .exe_busy_i(exe_busy), .de_hold_o(de_hold),
        .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .de_valid_o(de_valid), .de_pc_o(de_pc), .de_rs1_o(de_rs1), .de_rs2_o(de_rs2),
        .de_rs1_data_o(de_rs1_data), .de_rs2_data_o(de_rs2_data), .de_imm_o(de_imm),
        .de_rd_o(de_rd), .de_alu_op_o(de_alu_op), .de_wb_src_o(de_wb_src),
        .de_mem_read_o(de_mem_read), .de_mem_write_o(de_mem_write),
        .de_reg_write_o(de_reg_write)
    );

    exe_stage u_exe (
        .clk, .rst_i, .de_valid_i(de_valid), .de_pc_i(de_pc),
        .de_rs1_i(de_rs1), .de_rs2_i(de_rs2),
        .de_rs1_data_i(de_rs1_data), .de_rs2_data_i(de_rs2_data), .de_imm_i(de_imm),
        .de_rd_i(de_rd), .de_alu_op_i(de_alu_op), .de_wb_src_i(de_wb_src),
        .de_mem_read_i(de_mem_read), .de_mem_write_i(de_mem_write),
        .de_reg_write_i(de_reg_write), .mem_busy_i(mem_busy),
        .fwd_en_i(wb_en), .fwd_rd_i(wb_rd), .fwd_data_i(wb_data),
        .fwd_pending_i(fwd_pending), .exe_busy_o(exe_busy),
        .ex_valid_o(ex_valid), .ex_pc_o(ex_pc), .ex_result_o(ex_result),
        .ex_store_data_o(ex_store_data), .ex_rd_o(ex_rd), .ex_wb_src_o(ex_wb_src),
        .ex_mem_read_o(ex_mem_read), .ex_mem_write_o(ex_mem_write),
        .ex_reg_write_o(ex_reg_write)
    );

    mem_stage u_mem (
        .clk, .rst_i, .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_result_i(ex_result),
        .ex_store_data_i(ex_store_data), .ex_rd_i(ex_rd), .ex_wb_src_i(ex_wb_src),
        .ex_mem_read_i(ex_mem_read), .ex_mem_write_i(ex_mem_write),
        .ex_reg_write_i(ex_reg_write),
        .data_req_read_o(data_read), .data_req_write_o(data_write),
        .data_addr_o(data_addr), .data_wdata_o(data_wdata),
        .data_resp_i(data_resp), .data_rdata_i(data_rdata), .mem_busy_o(mem_busy),
        .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .fwd_pending_o(fwd_pending), .commit_valid_o, .commit_pc_o, .commit_rd_o,
        .commit_data_o
    );

    mem_arbiter u_arb (
        .clk, .rst_i, .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
        .fetch_resp_o(fetch_resp), .fetch_rdata_o(fetch_rdata),
        .data_read_i(data_read), .data_write_i(data_write),
        .data_addr_i(data_addr), .data_wdata_i(data_wdata),
        .data_resp_o(data_resp), .data_rdata_o(data_rdata),
        .mem_read_o, .mem_write_o, .mem_addr_o, .mem_wdata_o, .mem_resp_i, .mem_rdata_i
    );

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   fetch_req_i,
    input  rv32i_types_pkg::word_t fetch_addr_i,
    output logic                   fetch_resp_o,
    output rv32i_types_pkg::word_t fetch_rdata_o,
    input  logic                   data_read_i,
    input  logic                   data_write_i,
    input  rv32i_types_pkg::word_t data_addr_i,
    input  rv32i_types_pkg::word_t data_wdata_i,
    output logic                   data_resp_o,
    output rv32i_types_pkg::word_t data_rdata_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output rv32i_types_pkg::word_t mem_addr_o,
    output rv32i_types_pkg::word_t mem_wdata_o,
    input  logic                   mem_resp_i,
    input  rv32i_types_pkg::word_t mem_rdata_i
);

    logic busy_q;      // a request owns the port
    logic own_data_q;
    logic data_req;
    logic grant_data;

    assign data_req = data_read_i || data_write_i;
    // data wins only when the port is free
    assign grant_data = busy_q ? own_data_q : data_req;

    assign mem_read_o = grant_data ? data_read_i : fetch_req_i;
    assign mem_write_o = grant_data && data_write_i;
    assign mem_addr_o = grant_data ? data_addr_i : fetch_addr_i;
    assign mem_wdata_o = data_wdata_i;

    assign fetch_resp_o = mem_resp_i && busy_q && !own_data_q;
    assign data_resp_o = mem_resp_i && busy_q && own_data_q;
    assign fetch_rdata_o = mem_rdata_i;
    assign data_rdata_o = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            own_data_q <= 1'b0;
        end else if (mem_resp_i) begin
            busy_q <= 1'b0;
        end else if (!busy_q && (data_req || fetch_req_i)) begin
            busy_q <= 1'b1;
            own_data_q <= data_req;
        end
    end

    resp_has_owner: assert property (@(posedge clk) disable iff (rst_i)
        mem_resp_i |-> busy_q);

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       ex_valid_i,
    input  rv32i_types_pkg::word_t     ex_pc_i,
    input  rv32i_types_pkg::word_t     ex_result_i,
    input  rv32i_types_pkg::word_t     ex_store_data_i,
    input  rv32i_types_pkg::reg_idx_t  ex_rd_i,
    input  pipe_ctrl_pkg::wb_src_t     ex_wb_src_i,
    input  logic                       ex_mem_read_i,
    input  logic                       ex_mem_write_i,
    input  logic                       ex_reg_write_i,
    output logic                       data_req_read_o,
    output logic                       data_req_write_o,
    output rv32i_types_pkg::word_t     data_addr_o,
    output rv32i_types_pkg::word_t     data_wdata_o,
    input  logic                       data_resp_i,
    input  rv32i_types_pkg::word_t     data_rdata_i,
    output logic                       mem_busy_o,
    output logic                       wb_en_o,
    output rv32i_types_pkg::reg_idx_t  wb_rd_o,
    output rv32i_types_pkg::word_t     wb_data_o,
    output logic                       fwd_pending_o,
    output logic                       commit_valid_o,
    output rv32i_types_pkg::word_t     commit_pc_o,
    output rv32i_types_pkg::reg_idx_t  commit_rd_o,
    output rv32i_types_pkg::word_t     commit_data_o
);

    logic is_mem;
    logic done;

    assign is_mem = ex_mem_read_i || ex_mem_write_i;
    assign data_req_read_o = ex_valid_i && ex_mem_read_i;  // held by exe register
    assign data_req_write_o = ex_valid_i && ex_mem_write_i;
    assign data_addr_o = ex_result_i;
    assign data_wdata_o = ex_store_data_i;

    assign mem_busy_o = ex_valid_i && is_mem && !data_resp_i;
    assign done = ex_valid_i && (!is_mem || data_resp_i);
    assign fwd_pending_o = ex_valid_i && ex_mem_read_i && !data_resp_i;

    assign wb_data_o = (ex_wb_src_i == pipe_ctrl_pkg::wb_mem) ? data_rdata_i : ex_result_i;
    assign wb_rd_o = ex_rd_i;
    assign wb_en_o = done && ex_reg_write_i;

    assign commit_valid_o = done;
    assign commit_pc_o = ex_pc_i;
    assign commit_rd_o = ex_reg_write_i ? ex_rd_i : '0;  // stores report rd 0
    assign commit_data_o = ex_reg_write_i ? wb_data_o : '0;

    // decode never sets both, this guards the handoff through exe
    no_read_and_write: assert property (@(posedge clk) disable iff (rst_i)
        !(data_req_read_o && data_req_write_o));

endmodule

// File: source/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       de_valid_i,
    input  rv32i_types_pkg::word_t     de_pc_i,
    input  rv32i_types_pkg::reg_idx_t  de_rs1_i,
    input  rv32i_types_pkg::reg_idx_t  de_rs2_i,
    input  rv32i_types_pkg::word_t     de_rs1_data_i,
    input  rv32i_types_pkg::word_t     de_rs2_data_i,
    input  rv32i_types_pkg::word_t     de_imm_i,
    input  rv32i_types_pkg::reg_idx_t  de_rd_i,
    input  pipe_ctrl_pkg::alu_op_t     de_alu_op_i,
    input  pipe_ctrl_pkg::wb_src_t     de_wb_src_i,
    input  logic                       de_mem_read_i,
    input  logic                       de_mem_write_i,
    input  logic                       de_reg_write_i,
    input  logic                       mem_busy_i,
    input  logic                       fwd_en_i,
    input  rv32i_types_pkg::reg_idx_t  fwd_rd_i,
    input  rv32i_types_pkg::word_t     fwd_data_i,
    input  logic                       fwd_pending_i,
    output logic                       exe_busy_o,
    output logic                       ex_valid_o,
    output rv32i_types_pkg::word_t     ex_pc_o,
    output rv32i_types_pkg::word_t     ex_result_o,
    output rv32i_types_pkg::word_t     ex_store_data_o,
    output rv32i_types_pkg::reg_idx_t  ex_rd_o,
    output pipe_ctrl_pkg::wb_src_t     ex_wb_src_o,
    output logic                       ex_mem_read_o,
    output logic                       ex_mem_write_o,
    output logic                       ex_reg_write_o
);

    rv32i_types_pkg::word_t op_a;
    rv32i_types_pkg::word_t rs2_val;
    rv32i_types_pkg::word_t op_b;
    rv32i_types_pkg::word_t alu_res;
    logic hit1;
    logic hit2;
    logic ld_stall;

    // fwd_en only comes with a nonzero rd
    assign hit1 = fwd_en_i && fwd_rd_i == de_rs1_i;
    assign hit2 = fwd_en_i && fwd_rd_i == de_rs2_i;

    assign op_a = hit1 ? fwd_data_i : de_rs1_data_i;
    assign rs2_val = hit2 ? fwd_data_i : de_rs2_data_i;
    // stores use rs2 as data, not as operand
    assign op_b = (de_mem_write_i || de_rs2_i == '0) ? de_imm_i : rs2_val;

    always_comb begin
        unique case (de_alu_op_i)
            pipe_ctrl_pkg::alu_sub:    alu_res = op_a - op_b;
            pipe_ctrl_pkg::alu_pass_b: alu_res = op_b;
            default:                   alu_res = op_a + op_b;  // also load/store address
        endcase
    end

    // a load still waiting on memory has no data to forward yet
    assign ld_stall = de_valid_i && fwd_pending_i && fwd_rd_i != '0 &&
                      (fwd_rd_i == de_rs1_i || fwd_rd_i == de_rs2_i);
    assign exe_busy_o = mem_busy_i || ld_stall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
        end else if (!mem_busy_i) begin
            ex_valid_o <= de_valid_i && !ld_stall;  // bubble while waiting on a load
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy_i) begin
            ex_pc_o <= de_pc_i;
            ex_result_o <= alu_res;
            ex_store_data_o <= rs2_val;
            ex_rd_o <= de_rd_i;
            ex_wb_src_o <= de_wb_src_i;
            ex_mem_read_o <= de_mem_read_i;
            ex_mem_write_o <= de_mem_write_i;
            ex_reg_write_o <= de_reg_write_i;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       if_valid_i,
    input  rv32i_types_pkg::word_t     if_pc_i,
    input  rv32i_types_pkg::word_t     if_instr_i,
    input  logic                       exe_busy_i,
    output logic                       de_hold_o,
    input  logic                       wb_en_i,
    input  rv32i_types_pkg::reg_idx_t  wb_rd_i,
    input  rv32i_types_pkg::word_t     wb_data_i,
    output logic                       de_valid_o,
    output rv32i_types_pkg::word_t     de_pc_o,
    output rv32i_types_pkg::reg_idx_t  de_rs1_o,
    output rv32i_types_pkg::reg_idx_t  de_rs2_o,
    output rv32i_types_pkg::word_t     de_rs1_data_o,
    output rv32i_types_pkg::word_t     de_rs2_data_o,
    output rv32i_types_pkg::word_t     de_imm_o,
    output rv32i_types_pkg::reg_idx_t  de_rd_o,
    output pipe_ctrl_pkg::alu_op_t     de_alu_op_o,
    output pipe_ctrl_pkg::wb_src_t     de_wb_src_o,
    output logic                       de_mem_read_o,
    output logic                       de_mem_write_o,
    output logic                       de_reg_write_o
);

    rv32i_types_pkg::word_t    regs [`NUM_REGS];
    rv32i_types_pkg::instr_u   ins;
    rv32i_types_pkg::reg_idx_t rs1;
    rv32i_types_pkg::reg_idx_t rs2;
    rv32i_types_pkg::word_t    rs1_data;
    rv32i_types_pkg::word_t    rs2_data;
    rv32i_types_pkg::word_t    imm;
    pipe_ctrl_pkg::alu_op_t    alu_op;
    pipe_ctrl_pkg::wb_src_t    wb_src;
    logic supported;
    logic mem_rd;
    logic mem_wr;
    logic writes_rd;

    assign ins = if_instr_i;
    assign de_hold_o = de_valid_o && exe_busy_i;  // an empty slot can always fill

    always_comb begin
        supported = 1'b0;
        rs1 = ins.r_i.rs1;
        rs2 = ins.r_i.rs2;
        imm = '0;
        alu_op = pipe_ctrl_pkg::alu_add;
        wb_src = pipe_ctrl_pkg::wb_alu;
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        writes_rd = 1'b0;
        // rs2 index 0 tells exe that operand b is the immediate
        unique case (ins.r_i.opcode)
            rv32i_types_pkg::opc_op: begin
                supported = ins.r_i.funct3 == 3'b000 &&
                            (ins.r_i.funct7 == 7'b0000000 || ins.r_i.funct7 == 7'b0100000);
                if (ins.r_i.funct7[5]) alu_op = pipe_ctrl_pkg::alu_sub;
                writes_rd = 1'b1;
            end
            rv32i_types_pkg::opc_op_imm, rv32i_types_pkg::opc_load: begin
                supported = ins.r_i.opcode == rv32i_types_pkg::opc_load ?
                            ins.r_i.funct3 == 3'b010 : ins.r_i.funct3 == 3'b000;
                rs2 = '0;
                imm = {{20{ins.r_i.funct7[6]}}, ins.r_i.funct7, ins.r_i.rs2};
                mem_rd = ins.r_i.opcode == rv32i_types_pkg::opc_load;
                if (mem_rd) wb_src = pipe_ctrl_pkg::wb_mem;
                writes_rd = 1'b1;
            end
            rv32i_types_pkg::opc_lui: begin
                supported = 1'b1;
                rs1 = '0;
                rs2 = '0;
                imm = {ins.r_i.funct7, ins.r_i.rs2, ins.r_i.rs1, ins.r_i.funct3, 12'h000};
                alu_op = pipe_ctrl_pkg::alu_pass_b;
                writes_rd = 1'b1;
            end
            rv32i_types_pkg::opc_store: begin
                supported = ins.s.funct3 == 3'b010;
                imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
                mem_wr = 1'b1;
            end
            default: ;  // bubble
        endcase
    end

    // register file read with write-through from the memory stage
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_en_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_en_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

    always_ff @(posedge clk) begin
        if (wb_en_i && wb_rd_i != '0) regs[wb_rd_i] <= wb_data_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_valid_o <= 1'b0;
        end else if (!de_hold_o) begin
            de_valid_o <= if_valid_i && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (!de_hold_o) begin
            de_pc_o <= if_pc_i;
            de_rs1_o <= rs1;
            de_rs2_o <= rs2;
            de_rs1_data_o <= rs1_data;
            de_rs2_data_o <= rs2_data;
            de_imm_o <= imm;
            de_rd_o <= ins.r_i.rd;
            de_alu_op_o <= alu_op;
            de_wb_src_o <= wb_src;
            de_mem_read_o <= mem_rd;
            de_mem_write_o <= mem_wr;
            de_reg_write_o <= writes_rd && ins.r_i.rd != '0;
        end
    end

    // rd 0 is filtered here, so writeback never targets x0
    x0_never_written: assert property (@(posedge clk) disable iff (rst_i)
        wb_en_i |-> wb_rd_i != '0);

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   if_hold_i,
    output logic                   fetch_req_o,
    output rv32i_types_pkg::word_t fetch_addr_o,
    input  logic                   fetch_resp_i,
    input  rv32i_types_pkg::word_t fetch_rdata_i,
    output logic                   if_valid_o,
    output rv32i_types_pkg::word_t if_pc_o,
    output rv32i_types_pkg::word_t if_instr_o
);

    rv32i_types_pkg::word_t pc_q;
    logic run_q;   // first cycle out of reset stays quiet
    logic pend_q;  // request already on the bus
    logic slot_free;
    logic accept;

    assign slot_free = !if_valid_o || !if_hold_i;
    // a word that comes back while decode holds is dropped and fetched again
    assign accept = fetch_resp_i && slot_free;

    assign fetch_req_o = run_q && (pend_q || slot_free);
    assign fetch_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
            run_q <= 1'b0;
            pend_q <= 1'b0;
            if_valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            pend_q <= fetch_req_o && !fetch_resp_i;
            if (accept) begin
                pc_q <= pc_q + 'd4;
                if_valid_o <= 1'b1;
            end else if (!if_hold_i) begin
                if_valid_o <= 1'b0;  // consumed by decode
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if_pc_o <= pc_q;
            if_instr_o <= fetch_rdata_i;
        end
    end

endmodule

// File: source/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b  // lui
    } alu_op_t;

    // what gets written back to rd
    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_src_t;

endpackage

// File: source/rv32i_types_pkg.sv
`include "core_params.svh"

package rv32i_types_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // only the major opcodes this core knows about
    typedef enum logic [6:0] {
        opc_other  = 7'b0000000,
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111
    } opcode_t;

    // R and I layout, funct7 doubles as imm[11:5] for I-type
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } instr_r_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;  // sits where rd would be
        opcode_t    opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_i_t r_i;
        instr_s_t   s;
    } instr_u;

endpackage

// File: source/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width
`define XLEN 32
// architectural registers, x0 included
`define NUM_REGS 32
`define RESET_PC 32'h0000_0000

`endif
